//--- include/gcu_defs.svh
// ##########################################################
// widths and fixed latencies of the graphics control unit
// the VRAM pointer is 16 bits, only the low GCU_VRAM_AW
// bits address the RAM
// ##########################################################
`ifndef GCU_DEFS_SVH
`define GCU_DEFS_SVH

// bus and RAM word width
`define GCU_DATA_W 16

// 8K words of video RAM
`define GCU_VRAM_AW 13

// scroll output, low bits of the stored 16 bit value
`define GCU_SCROLL_W 13

// beam counters and sync window bounds
`define GCU_BEAM_W 9

// bits 4 to 6 of a select word are always dropped
`define GCU_REG_SEL_MASK 8'h8F

// edges from the sampling edge of a read to rd_valid,
// sampling edge included
`define GCU_READ_LATENCY 3

`endif

//--- source/gcu_pkg.sv
// ##########################################################
// shared types of the graphics control unit
// one command per valid cycle, no back-pressure
// ##########################################################
`default_nettype none

`include "gcu_defs.svh"

package gcu_pkg;

    typedef enum logic [2:0] {
        op_select_reg = 3'd0,
        op_write_reg  = 3'd1,
        op_set_ptr    = 3'd2,
        op_write_ram  = 3'd3,
        op_read_high  = 3'd4,
        op_read_low   = 3'd5
    } gcu_op_e;

    typedef struct packed {
        logic                   valid;
        gcu_op_e                op;
        logic [`GCU_DATA_W-1:0] data;
    } gcu_cmd_t;

    // select word, seen as a byte or as flag plus index
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic       flip_mode;
            logic [2:0] unused;
            logic [3:0] index;
        } dec;
    } gcu_reg_sel_u;

    typedef struct packed {
        logic [`GCU_SCROLL_W-1:0] scroll_x;
        logic [`GCU_SCROLL_W-1:0] scroll_y;
        logic                     flip_x;
        logic                     flip_y;
    } layer_scroll_t;

    typedef struct packed {
        layer_scroll_t background;
        layer_scroll_t foreground;
        layer_scroll_t text;
        layer_scroll_t sprite;
    } scroll_bank_t;

    typedef struct packed {
        logic [`GCU_BEAM_W-1:0] h;
        logic [`GCU_BEAM_W-1:0] v;
    } beam_pos_t;

    typedef struct packed {
        logic [`GCU_BEAM_W-1:0] hs_start;
        logic [`GCU_BEAM_W-1:0] hs_end;
        logic [`GCU_BEAM_W-1:0] vs_start;
        logic [`GCU_BEAM_W-1:0] vs_end;
    } sync_timing_t;

    // all three active low
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic blank;
    } sync_out_t;

endpackage

`default_nettype wire

//--- source/gcu_cpu_port.sv
// ##########################################################
// CPU side of the VRAM: pointer, writes and reads
// reads return in order after a fixed latency, up to three
// in flight; ram_addr and data regs carry no reset
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

`include "gcu_defs.svh"

module gcu_cpu_port
    import gcu_pkg::*;
(
    input  wire logic                     CLK96,
    input  wire logic                     RESET96,
    input  wire gcu_cmd_t                 cmd,
    output logic                          ram_we,
    output logic [`GCU_VRAM_AW-1:0]       ram_addr,
    output logic [`GCU_DATA_W-1:0]        ram_wdata,
    input  wire logic [`GCU_DATA_W-1:0]   ram_rdata,
    output logic                          rd_valid,
    output logic [`GCU_DATA_W-1:0]        rd_data
);

    // one stage for the address, one for the RAM output
    localparam int PEND_W = `GCU_READ_LATENCY - 1;

    logic [`GCU_DATA_W-1:0] ram_ptr;
    logic [PEND_W-1:0]      rd_pend;
    logic                   is_write;
    logic                   is_read;
    logic                   is_low;

    assign is_write = cmd.valid && (cmd.op == op_write_ram);
    assign is_read  = cmd.valid && (cmd.op == op_read_high || cmd.op == op_read_low);
    assign is_low   = (cmd.op == op_read_low);

    // pointer, write strobe and read tracking
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            ram_ptr  <= '0;
            ram_we   <= 1'b0;
            rd_pend  <= '0;
            rd_valid <= 1'b0;
        end else begin
            ram_we   <= is_write;
            rd_pend  <= {rd_pend[PEND_W-2:0], is_read};
            rd_valid <= rd_pend[PEND_W-1];
            if (cmd.valid) begin
                case (cmd.op)
                    op_set_ptr: begin
                        ram_ptr <= cmd.data;
                    end
                    // post-increment on every RAM write
                    op_write_ram: begin
                        ram_ptr <= ram_ptr + 1'b1;
                    end
                    default: begin
                        ram_ptr <= ram_ptr;
                    end
                endcase
            end
        end
    end

    // RAM address and write data
    always_ff @(posedge CLK96) begin
        if (is_write) begin
            ram_addr  <= ram_ptr[`GCU_VRAM_AW-1:0];
            ram_wdata <= cmd.data;
        end else if (is_read) begin
            // low word sits one above the pointer
            ram_addr <= ram_ptr[`GCU_VRAM_AW-1:0] + {{(`GCU_VRAM_AW-1){1'b0}}, is_low};
        end
    end

    // capture RAM output for the oldest pending read
    always_ff @(posedge CLK96) begin
        if (rd_pend[PEND_W-1]) begin
            rd_data <= ram_rdata;
        end
    end

    // port A carries either a write or a read, never both
    a_no_write_during_read : assert property (
        @(posedge CLK96) disable iff (RESET96)
        !(ram_we && rd_pend[0])
    );

endmodule

`default_nettype wire

//--- source/gcu_scroll_regs.sv
// ##########################################################
// register select, eight scroll registers and flip bits
// board flip inputs must be static, the flip bits load
// their inverse during reset
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

`include "gcu_defs.svh"

module gcu_scroll_regs
    import gcu_pkg::*;
(
    input  wire logic     CLK96,
    input  wire logic     RESET96,
    input  wire gcu_cmd_t cmd,
    input  wire logic     flip_x,
    input  wire logic     flip_y,
    output scroll_bank_t  scroll
);

    gcu_reg_sel_u           sel;
    logic [`GCU_DATA_W-1:0] scroll_val [8];
    // even index is an x flip, odd index a y flip
    logic [7:0]             flip_bits;

    logic                   sel_hit;
    logic                   wr_hit;
    logic [2:0]             wr_idx;
    logic                   wr_board;
    logic                   wr_flip;

    assign sel_hit = cmd.valid && (cmd.op == op_select_reg);
    // indices 8 and up are not scroll registers
    assign wr_hit  = cmd.valid && (cmd.op == op_write_reg) && !sel.dec.index[3];
    assign wr_idx  = sel.dec.index[2:0];
    assign wr_board = wr_idx[0] ? flip_y : flip_x;

    // flip mode sets from the board input, otherwise clears
    assign wr_flip = sel.dec.flip_mode ? (flip_bits[wr_idx] | wr_board)
                                       : (flip_bits[wr_idx] & ~wr_board);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sel.raw   <= '0;
            flip_bits <= {4{~flip_y, ~flip_x}};
            for (int i = 0; i < 8; i++) begin
                scroll_val[i] <= '0;
            end
        end else begin
            if (sel_hit) begin
                sel.raw <= cmd.data[7:0] & `GCU_REG_SEL_MASK;
            end
            if (wr_hit) begin
                scroll_val[wr_idx] <= cmd.data;
                flip_bits[wr_idx]  <= wr_flip;
            end
        end
    end

    function automatic layer_scroll_t pack_layer(
        input logic [`GCU_DATA_W-1:0] x,
        input logic [`GCU_DATA_W-1:0] y,
        input logic                   fx,
        input logic                   fy
    );
        layer_scroll_t l;
        l.scroll_x = x[`GCU_SCROLL_W-1:0];
        l.scroll_y = y[`GCU_SCROLL_W-1:0];
        l.flip_x   = fx;
        l.flip_y   = fy;
        return l;
    endfunction

    // register pairs 0/1 bg, 2/3 fg, 4/5 text, 6/7 sprite
    assign scroll.background = pack_layer(scroll_val[0], scroll_val[1],
                                          flip_bits[0], flip_bits[1]);
    assign scroll.foreground = pack_layer(scroll_val[2], scroll_val[3],
                                          flip_bits[2], flip_bits[3]);
    assign scroll.text       = pack_layer(scroll_val[4], scroll_val[5],
                                          flip_bits[4], flip_bits[5]);
    assign scroll.sprite     = pack_layer(scroll_val[6], scroll_val[7],
                                          flip_bits[6], flip_bits[7]);

    // mask holds across every select
    a_sel_masked : assert property (
        @(posedge CLK96) disable iff (RESET96)
        sel.raw[6:4] == 3'b000
    );

endmodule

`default_nettype wire

//--- source/gcu_vram.sv
// ##########################################################
// 8K x 16 video RAM, one read/write port for the CPU and
// one read-only port for the renderer
// both ports read one edge after the address, read-first
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

`include "gcu_defs.svh"

module gcu_vram (
    input  wire logic                     CLK96,
    input  wire logic                     we,
    input  wire logic [`GCU_VRAM_AW-1:0]  addr,
    input  wire logic [`GCU_DATA_W-1:0]   wdata,
    output logic [`GCU_DATA_W-1:0]        rdata,
    input  wire logic [`GCU_VRAM_AW-1:0]  ren_addr,
    output logic [`GCU_DATA_W-1:0]        ren_data
);

    logic [`GCU_DATA_W-1:0] mem [2**`GCU_VRAM_AW];

    // port A, CPU
    always_ff @(posedge CLK96) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

    // port B, renderer
    always_ff @(posedge CLK96) begin
        ren_data <= mem[ren_addr];
    end

endmodule

`default_nettype wire

//--- source/gcu_video_timing.sv
// ##########################################################
// registered hsync, vsync and blank from beam position
// outputs follow the inputs of the previous cycle
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

`include "gcu_defs.svh"

module gcu_video_timing
    import gcu_pkg::*;
(
    input  wire logic         CLK96,
    input  wire logic         RESET96,
    input  wire beam_pos_t    beam,
    input  wire sync_timing_t timing,
    output sync_out_t         sync
);

    logic in_hsync;
    logic in_vsync;

    // horizontal window excludes both ends
    assign in_hsync = (beam.h > timing.hs_start) && (beam.h < timing.hs_end);
    // vertical window includes both ends
    assign in_vsync = (beam.v >= timing.vs_start) && (beam.v <= timing.vs_end);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sync.hsync <= 1'b1;
            sync.vsync <= 1'b1;
            sync.blank <= 1'b1;
        end else begin
            sync.hsync <= ~in_hsync;
            sync.vsync <= ~in_vsync;
            sync.blank <= ~(in_hsync | in_vsync);
        end
    end

    a_blank_covers_sync : assert property (
        @(posedge CLK96) disable iff (RESET96)
        (!sync.hsync || !sync.vsync) |-> !sync.blank
    );

endmodule

`default_nettype wire

//--- source/gp9001_gcu.sv
// ##########################################################
// GP9001-style graphics control unit, CPU facing core
// single 96 MHz domain, command strobe without back-pressure
// tile banking and ROM fetch live outside this block
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

`include "gcu_defs.svh"

module gp9001_gcu
    import gcu_pkg::*;
(
    input  wire logic                     CLK96,
    input  wire logic                     RESET96,
    input  wire gcu_cmd_t                 cmd,
    output logic                          rd_valid,
    output logic [`GCU_DATA_W-1:0]        rd_data,
    input  wire logic [`GCU_VRAM_AW-1:0]  ren_addr,
    output logic [`GCU_DATA_W-1:0]        ren_data,
    input  wire logic                     flip_x,
    input  wire logic                     flip_y,
    output scroll_bank_t                  scroll,
    input  wire beam_pos_t                beam,
    input  wire sync_timing_t             timing,
    output sync_out_t                     sync
);

    // CPU port to VRAM port A
    logic                     ram_we;
    logic [`GCU_VRAM_AW-1:0]  ram_addr;
    logic [`GCU_DATA_W-1:0]   ram_wdata;
    logic [`GCU_DATA_W-1:0]   ram_rdata;

    gcu_cpu_port u_cpu_port (
        .CLK96     (CLK96),
        .RESET96   (RESET96),
        .cmd       (cmd),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    gcu_scroll_regs u_scroll_regs (
        .CLK96   (CLK96),
        .RESET96 (RESET96),
        .cmd     (cmd),
        .flip_x  (flip_x),
        .flip_y  (flip_y),
        .scroll  (scroll)
    );

    gcu_vram u_vram (
        .CLK96    (CLK96),
        .we       (ram_we),
        .addr     (ram_addr),
        .wdata    (ram_wdata),
        .rdata    (ram_rdata),
        .ren_addr (ren_addr),
        .ren_data (ren_data)
    );

    gcu_video_timing u_video_timing (
        .CLK96   (CLK96),
        .RESET96 (RESET96),
        .beam    (beam),
        .timing  (timing),
        .sync    (sync)
    );

endmodule

`default_nettype wire

//--- testbench/tb_gp9001_gcu.sv
// ##########################################################
// directed testbench for the graphics control unit
// board flip inputs held at x=1, y=0 for the whole run
// stops at the first error, every read wait has a timeout
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

`include "gcu_defs.svh"

module tb_gp9001_gcu
    import gcu_pkg::*;
();

    localparam int              READ_EDGES   = 3;
    localparam int              READ_TIMEOUT = 20;
    localparam logic [15:0]     BASE_PTR     = 16'hE5C0;

    logic                       CLK96;
    logic                       RESET96;
    gcu_cmd_t                   cmd;
    logic                       rd_valid;
    logic [`GCU_DATA_W-1:0]     rd_data;
    logic [`GCU_VRAM_AW-1:0]    ren_addr;
    logic [`GCU_DATA_W-1:0]     ren_data;
    logic                       flip_x;
    logic                       flip_y;
    scroll_bank_t               scroll;
    beam_pos_t                  beam;
    sync_timing_t               timing;
    sync_out_t                  sync;

    logic [15:0]                lfsr_state;
    int                         fail_count;
    logic [`GCU_DATA_W-1:0]     ram_words [8];
    // expected scroll values and flip bits, even index x, odd y
    logic [`GCU_DATA_W-1:0]     exp_val [8];
    logic [7:0]                 exp_flip;

    gp9001_gcu u_dut (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .cmd      (cmd),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .ren_addr (ren_addr),
        .ren_data (ren_data),
        .flip_x   (flip_x),
        .flip_y   (flip_y),
        .scroll   (scroll),
        .beam     (beam),
        .timing   (timing),
        .sync     (sync)
    );

    initial begin
        CLK96 = 1'b0;
        forever #2 CLK96 = ~CLK96;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    task automatic random_word(output logic [15:0] word);
        word = '0;
        for (int b = 0; b < 16; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            word = {word[14:0], lfsr_state[0]};
        end
    endtask

    task automatic stop_run(input string reason);
        fail_count++;
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            stop_run($sformatf("Fail %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    task automatic send_cmd(input gcu_op_e op, input logic [15:0] data);
        @(negedge CLK96);
        cmd.valid = 1'b1;
        cmd.op    = op;
        cmd.data  = data;
    endtask

    task automatic drive_idle();
        @(negedge CLK96);
        cmd.valid = 1'b0;
        cmd.op    = op_select_reg;
        cmd.data  = '0;
    endtask

    // edges counts rising edges from the sampling edge on
    task automatic read_word(input string name, input gcu_op_e op, input logic [15:0] expected);
        int edges;
        send_cmd(op, 16'h0000);
        drive_idle();
        edges = 1;
        while (rd_valid !== 1'b1) begin
            if (edges >= READ_TIMEOUT) begin
                stop_run($sformatf("%s: read data never returned", name));
            end else begin
                @(negedge CLK96);
                edges++;
            end
        end
        check_value({name, " latency"}, 32'(READ_EDGES), 32'(edges));
        check_value({name, " data"}, 32'(expected), 32'(rd_data));
        @(negedge CLK96);
        check_value({name, " valid width"}, 32'd0, 32'(rd_valid));
    endtask

    task automatic read_three(input string name, input gcu_op_e op0, input gcu_op_e op1,
                              input gcu_op_e op2, input logic [15:0] exp0,
                              input logic [15:0] exp1, input logic [15:0] exp2);
        logic [15:0] expected [3];
        int          got;
        int          waited;
        expected[0] = exp0;
        expected[1] = exp1;
        expected[2] = exp2;
        got = 0;
        waited = 0;
        send_cmd(op0, 16'h0000);
        send_cmd(op1, 16'h0000);
        send_cmd(op2, 16'h0000);
        drive_idle();
        // first result is due right after the third command
        while (got < 3) begin
            if (waited >= READ_TIMEOUT) begin
                stop_run($sformatf("%s: only %0d of 3 reads returned", name, got));
            end else begin
                if (rd_valid === 1'b1) begin
                    check_value($sformatf("%s return cycle %0d", name, got),
                                32'(got), 32'(waited));
                    check_value($sformatf("%s data %0d", name, got),
                                32'(expected[got[1:0]]), 32'(rd_data));
                    got++;
                end
                @(negedge CLK96);
                waited++;
            end
        end
        check_value({name, " valid end"}, 32'd0, 32'(rd_valid));
    endtask

    function automatic layer_scroll_t layer_of(input scroll_bank_t bank, input int pair);
        case (pair)
            0: return bank.background;
            1: return bank.foreground;
            2: return bank.text;
            default: return bank.sprite;
        endcase
    endfunction

    task automatic check_bank(input string name);
        layer_scroll_t            layer;
        logic [`GCU_SCROLL_W-1:0] value;
        logic                     flip;
        for (int i = 0; i < 8; i++) begin
            layer = layer_of(scroll, i / 2);
            value = (i % 2 == 1) ? layer.scroll_y : layer.scroll_x;
            flip  = (i % 2 == 1) ? layer.flip_y : layer.flip_x;
            check_value($sformatf("%s scroll %0d", name, i),
                        32'(exp_val[i[2:0]][`GCU_SCROLL_W-1:0]), 32'(value));
            check_value($sformatf("%s flip %0d", name, i),
                        32'(exp_flip[i[2:0]]), 32'(flip));
        end
    endtask

    // select, then write in the next cycle, then compare the whole bank
    task automatic write_reg(input string name, input logic [7:0] sel_byte,
                             input logic [15:0] data);
        logic [7:0] masked;
        logic [2:0] idx;
        logic       board;
        masked = sel_byte & 8'h8F;
        idx    = masked[2:0];
        send_cmd(op_select_reg, {8'h5A, sel_byte});
        send_cmd(op_write_reg, data);
        drive_idle();
        if (masked[3] == 1'b0) begin
            board        = idx[0] ? flip_y : flip_x;
            exp_val[idx] = data;
            if (masked[7]) begin
                exp_flip[idx] = exp_flip[idx] | board;
            end else begin
                exp_flip[idx] = exp_flip[idx] & ~board;
            end
        end
        check_bank(name);
    endtask

    task automatic render_word(input string name, input logic [`GCU_VRAM_AW-1:0] addr,
                               input logic [15:0] expected);
        @(negedge CLK96);
        ren_addr = addr;
        @(negedge CLK96);
        check_value(name, 32'(expected), 32'(ren_data));
    endtask

    task automatic sync_case(input string name, input logic [8:0] h, input logic [8:0] v,
                             input logic [8:0] hs_s, input logic [8:0] hs_e,
                             input logic [8:0] vs_s, input logic [8:0] vs_e);
        logic      hs_low;
        logic      vs_low;
        sync_out_t expected;
        @(negedge CLK96);
        beam.h          = h;
        beam.v          = v;
        timing.hs_start = hs_s;
        timing.hs_end   = hs_e;
        timing.vs_start = vs_s;
        timing.vs_end   = vs_e;
        hs_low = (h > hs_s) && (h < hs_e);
        vs_low = (v >= vs_s) && (v <= vs_e);
        expected.hsync = ~hs_low;
        expected.vsync = ~vs_low;
        expected.blank = ~(hs_low | vs_low);
        @(negedge CLK96);
        check_value(name, 32'(expected), 32'(sync));
    endtask

    // checked at once, before any edge after reset release
    task automatic after_reset_state();
        for (int i = 0; i < 8; i++) begin
            exp_val[i[2:0]]  = '0;
            exp_flip[i[2:0]] = (i % 2 == 1) ? ~flip_y : ~flip_x;
        end
        check_value("reset rd_valid", 32'd0, 32'(rd_valid));
        check_value("reset sync", 32'h7, 32'(sync));
        check_bank("reset bank");
    endtask

    task automatic ram_write_burst();
        logic [15:0] w;
        send_cmd(op_set_ptr, BASE_PTR);
        for (int i = 0; i < 8; i++) begin
            random_word(w);
            ram_words[i[2:0]] = w;
            send_cmd(op_write_ram, w);
        end
        send_cmd(op_set_ptr, BASE_PTR);
        drive_idle();
        for (int i = 0; i < 8; i++) begin
            send_cmd(op_set_ptr, BASE_PTR + 16'(i));
            read_word($sformatf("burst word %0d", i), op_read_high, ram_words[i[2:0]]);
        end
    endtask

    task automatic read_low_and_repeat();
        send_cmd(op_set_ptr, BASE_PTR + 16'd2);
        read_word("read low", op_read_low, ram_words[3]);
        read_word("read high after low", op_read_high, ram_words[2]);
        read_word("repeated read high", op_read_high, ram_words[2]);
        send_cmd(op_set_ptr, BASE_PTR + 16'd5);
        read_three("back to back reads", op_read_high, op_read_low, op_read_high,
                   ram_words[5], ram_words[6], ram_words[5]);
    endtask

    // pointer bits above 12 do not reach the RAM
    task automatic render_readback();
        for (int i = 0; i < 8; i++) begin
            render_word($sformatf("render word %0d", i),
                        BASE_PTR[`GCU_VRAM_AW-1:0] + 13'(i), ram_words[i[2:0]]);
        end
    endtask

    task automatic scroll_register_writes();
        logic [15:0] w;
        for (int i = 0; i < 8; i++) begin
            random_word(w);
            write_reg($sformatf("flag set index %0d", i), 8'h80 | 8'(i), w);
        end
        for (int i = 0; i < 8; i++) begin
            random_word(w);
            write_reg($sformatf("flag clear index %0d", i), 8'(i), w);
        end
        random_word(w);
        write_reg("select 10 as index 0", 8'h10, w);
        random_word(w);
        write_reg("index 9 ignored", 8'h09, w);
    endtask

    task automatic sync_windows();
        sync_case("hsync at start", 9'd100, 9'd10, 9'd100, 9'd140, 9'd20, 9'd25);
        sync_case("hsync inside", 9'd101, 9'd10, 9'd100, 9'd140, 9'd20, 9'd25);
        sync_case("both inside", 9'd139, 9'd20, 9'd100, 9'd140, 9'd20, 9'd25);
        sync_case("vsync at end", 9'd140, 9'd25, 9'd100, 9'd140, 9'd20, 9'd25);
        sync_case("both outside", 9'd200, 9'd26, 9'd100, 9'd140, 9'd20, 9'd25);
        sync_case("vsync before start", 9'd120, 9'd19, 9'd100, 9'd140, 9'd20, 9'd25);
    endtask

    initial begin
        RESET96         = 1'b1;
        cmd             = '0;
        ren_addr        = '0;
        flip_x          = 1'b1;
        flip_y          = 1'b0;
        beam            = '0;
        timing.hs_start = 9'd0;
        timing.hs_end   = 9'd0;
        // empty vertical window while idle
        timing.vs_start = 9'd1;
        timing.vs_end   = 9'd0;
        lfsr_state      = 16'd83;
        fail_count      = 0;
        repeat (3) @(posedge CLK96);
        @(negedge CLK96);
        RESET96 = 1'b0;

        after_reset_state();
        ram_write_burst();
        read_low_and_repeat();
        render_readback();
        scroll_register_writes();
        sync_windows();

        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- gp9001_gcu.f
+incdir+include
source/gcu_pkg.sv
source/gcu_cpu_port.sv
source/gcu_scroll_regs.sv
source/gcu_vram.sv
source/gcu_video_timing.sv
source/gp9001_gcu.sv
testbench/tb_gp9001_gcu.sv

//--- run.sh
#!/bin/sh
# compile the testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f gp9001_gcu.f --top-module tb_gp9001_gcu \
    -Mdir obj_dir -o sim_gp9001_gcu
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit 1
fi

output=$(./obj_dir/sim_gp9001_gcu 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
